// ==== common/board_pkg.sv ====
package board_pkg;

	// debounce and reset timing, in clk_cpu cycles
	localparam int DEBOUNCE_CYCLES = 8;
	localparam int DEBOUNCE_W = $clog2(DEBOUNCE_CYCLES + 1);
	localparam int RESET_HOLD = 16;

	// interrupt lines 1 to 30
	localparam int IRQ_COUNT = 30;
	localparam int IRQ_HOLD = 3;
	localparam int IRQ_HOLD_W = $clog2(IRQ_HOLD + 1);
	localparam int IRQ_POS_BOARD = 2;
	localparam int IRQ_POS_KBD = 3;
	localparam int IRQ_POS_SPI = 5;
	localparam int IRQ_POS_UART = 6;

	// peripheral bus
	localparam int WORD_W = 32;
	localparam int DEV_SLOTS = 10;
	localparam int SLOT_BOARD = 2;

	typedef logic [15:0] switch_t;
	typedef logic [3:0] btn_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [3:0] bsel_t;
	typedef logic [15:2] bus_addr_t;
	typedef logic [7:2] dev_addr_t;
	typedef logic [IRQ_COUNT:1] irq_vec_t;

	// board register word offsets
	localparam dev_addr_t REG_SWITCH = 6'd0;
	localparam dev_addr_t REG_BTN = 6'd1;
	localparam dev_addr_t REG_LED = 6'd2;
	localparam dev_addr_t REG_EVENT = 6'd3;

endpackage

// ==== design/debounce.sv ====
`timescale 1ns/1ps

module debounce import board_pkg::*; #(
	parameter type sig_t = logic,
	parameter sig_t INIT = sig_t'(0)
) (
	input logic clk_cpu,
	input logic rst_n_i,
	input sig_t sig_i,
	output sig_t sig_o
);

	sig_t last_q;
	logic [DEBOUNCE_W-1:0] cnt_q;

	// whole payload compared at once, any change restarts the count
	always_ff @(posedge clk_cpu) begin
		if (!rst_n_i) begin
			last_q <= INIT;
			cnt_q <= '0;
			sig_o <= INIT;
		end else if (sig_i != last_q) begin
			last_q <= sig_i;
			cnt_q <= DEBOUNCE_W'(1);
		end else if (cnt_q != DEBOUNCE_W'(DEBOUNCE_CYCLES)) begin
			cnt_q <= cnt_q + 1'b1;
		end else begin
			// stable long enough
			sig_o <= last_q;
		end
	end

	assert property (@(posedge clk_cpu) disable iff (!rst_n_i)
		($past(rst_n_i) && $changed(sig_o)) |-> ($past(sig_i) == sig_o));

endmodule

// ==== design/reset_seq.sv ====
`timescale 1ns/1ps

module reset_seq import board_pkg::*; (
	input logic clk_cpu,
	input logic rst_n_i,
	input logic btn_rst_i,
	input logic pll_locked_i,
	input logic wd_rst_i,
	output logic sys_rst_o,
	output logic bus_rst_o
);

	logic bad;
	logic bad_q;
	logic [RESET_HOLD-1:0] hold_q;

	// button held or pll not locked
	assign bad = btn_rst_i | ~pll_locked_i;

	always_ff @(posedge clk_cpu) begin
		if (!rst_n_i) begin
			bad_q <= 1'b1;
			hold_q <= '1;
			sys_rst_o <= 1'b1;
		end else begin
			bad_q <= bad;
			hold_q <= {hold_q[RESET_HOLD-2:0], bad_q};
			// a new fault asserts at once, release waits for the chain to drain
			sys_rst_o <= bad | (|hold_q);
		end
	end

	// watchdog only resets the bus side
	assign bus_rst_o = sys_rst_o | wd_rst_i;

	assert property (@(posedge clk_cpu) disable iff (!rst_n_i)
		!pll_locked_i |=> sys_rst_o);

endmodule

// ==== design/irq_stretch.sv ====
`timescale 1ns/1ps

module irq_stretch import board_pkg::*; (
	input logic clk_cpu,
	input logic rst_n_i,
	input logic irq_board_i,
	input logic irq_kbd_i,
	input logic irq_spi_i,
	input logic irq_uart_i,
	output irq_vec_t irq_o
);

	irq_vec_t src;
	logic [IRQ_HOLD_W-1:0] cnt_q [1:IRQ_COUNT];

	// fixed line positions, unused lines stay low
	always_comb begin
		src = '0;
		src[IRQ_POS_BOARD] = irq_board_i;
		src[IRQ_POS_KBD] = irq_kbd_i;
		src[IRQ_POS_SPI] = irq_spi_i;
		src[IRQ_POS_UART] = irq_uart_i;
	end

	always_ff @(posedge clk_cpu) begin
		if (!rst_n_i) begin
			irq_o <= '0;
			for (int i = 1; i <= IRQ_COUNT; i++) begin
				cnt_q[i] <= '0;
			end
		end else begin
			for (int i = 1; i <= IRQ_COUNT; i++) begin
				// reload while source high, else run down
				if (src[i]) begin
					cnt_q[i] <= IRQ_HOLD_W'(IRQ_HOLD);
				end else if (cnt_q[i] != '0) begin
					cnt_q[i] <= cnt_q[i] - 1'b1;
				end
				irq_o[i] <= src[i] | (cnt_q[i] != '0);
			end
		end
	end

	// single-cycle source gives IRQ_HOLD+1 cycles out
	assert property (@(posedge clk_cpu) disable iff (!rst_n_i)
		(src[IRQ_POS_UART] ##1 !src[IRQ_POS_UART] [*IRQ_HOLD])
		|-> irq_o[IRQ_POS_UART]);

endmodule

// ==== devbus/dev_decoder.sv ====
`timescale 1ns/1ps

module dev_decoder import board_pkg::*; (
	input logic clk_cpu,
	input logic rst_n_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input bus_addr_t wb_addr_i,
	input bsel_t wb_sel_i,
	input logic wb_we_i,
	input word_t wb_data_i,
	output word_t wb_data_o,
	output logic wb_ack_o,
	output logic [DEV_SLOTS-1:0] dev_cs_o,
	output dev_addr_t dev_addr_o,
	output bsel_t dev_sel_o,
	output logic dev_we_o,
	output word_t dev_wdata_o,
	input logic [DEV_SLOTS*WORD_W-1:0] dev_rdata_i,
	input logic [DEV_SLOTS-1:0] dev_ack_i
);

	logic [15:8] slot;
	logic req;
	word_t rdata_sel;
	logic ack_sel;

	assign slot = wb_addr_i[15:8];
	assign req = wb_cyc_i & wb_stb_i;

	// shared by every slot
	assign dev_addr_o = wb_addr_i[7:2];
	assign dev_sel_o = wb_sel_i;
	assign dev_we_o = wb_we_i;
	assign dev_wdata_o = wb_data_i;

	// one-hot select plus return path from the addressed slot
	always_comb begin
		dev_cs_o = '0;
		// no device there, answer right away with zero
		rdata_sel = '0;
		ack_sel = 1'b1;
		for (int i = 0; i < DEV_SLOTS; i++) begin
			if (slot == i) begin
				dev_cs_o[i] = req;
				rdata_sel = dev_rdata_i[i*WORD_W +: WORD_W];
				ack_sel = dev_ack_i[i];
			end
		end
	end

	assign wb_ack_o = req & ack_sel;
	assign wb_data_o = rdata_sel;

	assert property (@(posedge clk_cpu) disable iff (!rst_n_i)
		$onehot0(dev_cs_o));

	// master holds stb until ack, so ack never stands alone
	assert property (@(posedge clk_cpu) disable iff (!rst_n_i)
		wb_ack_o |-> (wb_stb_i && wb_cyc_i));

endmodule

// ==== devbus/board_regs.sv ====
`timescale 1ns/1ps

module board_regs import board_pkg::*; (
	input logic clk_cpu,
	input logic rst_n_i,
	input logic cs_i,
	input dev_addr_t addr_i,
	input bsel_t sel_i,
	input logic we_i,
	input word_t wdata_i,
	input switch_t switch_i,
	input btn_t btn_i,
	output word_t rdata_o,
	output logic ack_o,
	output switch_t led_o,
	output logic irq_o
);

	logic cs_q;
	logic hit;
	btn_t btn_q;
	btn_t event_q;
	btn_t evt_clr;
	word_t rd_word;

	// only the first cycle of a select is served
	assign hit = cs_i & ~cs_q;

	always_comb begin
		case (addr_i)
			REG_SWITCH: rd_word = word_t'(switch_i);
			REG_BTN: rd_word = word_t'(btn_i);
			REG_LED: rd_word = word_t'(led_o);
			REG_EVENT: rd_word = word_t'(event_q);
			default: rd_word = '0;
		endcase
	end

	// write 1 to clear
	assign evt_clr = (hit && we_i && sel_i[0] && addr_i == REG_EVENT) ?
		btn_t'(wdata_i) : '0;

	always_ff @(posedge clk_cpu) begin
		if (!rst_n_i) begin
			cs_q <= 1'b0;
			ack_o <= 1'b0;
			led_o <= '0;
			btn_q <= '0;
			event_q <= '0;
		end else begin
			cs_q <= cs_i;
			ack_o <= hit;
			btn_q <= btn_i;
			// a new press wins over a clear in the same cycle
			event_q <= (event_q & ~evt_clr) | (btn_i & ~btn_q);
			if (hit && we_i && addr_i == REG_LED) begin
				for (int b = 0; b < $bits(switch_t) / 8; b++) begin
					if (sel_i[b]) begin
						led_o[b*8 +: 8] <= wdata_i[b*8 +: 8];
					end
				end
			end
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (hit) begin
			rdata_o <= rd_word;
		end
	end

	assign irq_o = |event_q;

	assert property (@(posedge clk_cpu) disable iff (!rst_n_i)
		ack_o |=> !ack_o);

endmodule

// ==== design/board_support.sv ====
`timescale 1ns/1ps

module board_support import board_pkg::*; (
	input logic clk_cpu,
	input logic rst_n_i,
	input logic pll_locked_i,
	input logic btn_rst_i,
	input logic wd_rst_i,
	input switch_t switch_i,
	input btn_t btn_i,
	input logic irq_kbd_i,
	input logic irq_spi_i,
	input logic irq_uart_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input bus_addr_t wb_addr_i,
	input bsel_t wb_sel_i,
	input logic wb_we_i,
	input word_t wb_data_i,
	output word_t wb_data_o,
	output logic wb_ack_o,
	output logic [DEV_SLOTS-1:0] dev_cs_o,
	output dev_addr_t dev_addr_o,
	output bsel_t dev_sel_o,
	output logic dev_we_o,
	output word_t dev_wdata_o,
	input logic [DEV_SLOTS*WORD_W-1:0] dev_rdata_i,
	input logic [DEV_SLOTS-1:0] dev_ack_i,
	output irq_vec_t irq_o,
	output switch_t led_o,
	output logic sys_rst_o,
	output logic bus_rst_o
);

	switch_t switch_db;
	btn_t btn_db;
	logic btn_rst_db;
	logic bus_rst_n;
	logic irq_board;
	logic [DEV_SLOTS-1:0] dec_cs;
	logic [DEV_SLOTS*WORD_W-1:0] dec_rdata;
	logic [DEV_SLOTS-1:0] dec_ack;
	word_t board_rdata;
	logic board_ack;

	// input conditioning
	debounce #(.sig_t(switch_t), .INIT('0)) u_db_switch (
		.clk_cpu(clk_cpu),
		.rst_n_i(rst_n_i),
		.sig_i(switch_i),
		.sig_o(switch_db)
	);

	debounce #(.sig_t(btn_t), .INIT('0)) u_db_btn (
		.clk_cpu(clk_cpu),
		.rst_n_i(rst_n_i),
		.sig_i(btn_i),
		.sig_o(btn_db)
	);

	// reset button counts as pressed until it settles
	debounce #(.sig_t(logic), .INIT(1'b1)) u_db_rst (
		.clk_cpu(clk_cpu),
		.rst_n_i(rst_n_i),
		.sig_i(btn_rst_i),
		.sig_o(btn_rst_db)
	);

	reset_seq u_reset_seq (
		.clk_cpu(clk_cpu),
		.rst_n_i(rst_n_i),
		.btn_rst_i(btn_rst_db),
		.pll_locked_i(pll_locked_i),
		.wd_rst_i(wd_rst_i),
		.sys_rst_o(sys_rst_o),
		.bus_rst_o(bus_rst_o)
	);

	assign bus_rst_n = ~bus_rst_o;

	irq_stretch u_irq_stretch (
		.clk_cpu(clk_cpu),
		.rst_n_i(bus_rst_n),
		.irq_board_i(irq_board),
		.irq_kbd_i(irq_kbd_i),
		.irq_spi_i(irq_spi_i),
		.irq_uart_i(irq_uart_i),
		.irq_o(irq_o)
	);

	// board slot stays on chip
	always_comb begin
		dec_rdata = dev_rdata_i;
		dec_rdata[SLOT_BOARD*WORD_W +: WORD_W] = board_rdata;
		dec_ack = dev_ack_i;
		dec_ack[SLOT_BOARD] = board_ack;
		dev_cs_o = dec_cs;
		dev_cs_o[SLOT_BOARD] = 1'b0;
	end

	dev_decoder u_dev_decoder (
		.clk_cpu(clk_cpu),
		.rst_n_i(bus_rst_n),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_addr_i(wb_addr_i),
		.wb_sel_i(wb_sel_i),
		.wb_we_i(wb_we_i),
		.wb_data_i(wb_data_i),
		.wb_data_o(wb_data_o),
		.wb_ack_o(wb_ack_o),
		.dev_cs_o(dec_cs),
		.dev_addr_o(dev_addr_o),
		.dev_sel_o(dev_sel_o),
		.dev_we_o(dev_we_o),
		.dev_wdata_o(dev_wdata_o),
		.dev_rdata_i(dec_rdata),
		.dev_ack_i(dec_ack)
	);

	board_regs u_board_regs (
		.clk_cpu(clk_cpu),
		.rst_n_i(bus_rst_n),
		.cs_i(dec_cs[SLOT_BOARD]),
		.addr_i(dev_addr_o),
		.sel_i(dev_sel_o),
		.we_i(dev_we_o),
		.wdata_i(dev_wdata_o),
		.switch_i(switch_db),
		.btn_i(btn_db),
		.rdata_o(board_rdata),
		.ack_o(board_ack),
		.led_o(led_o),
		.irq_o(irq_board)
	);

endmodule

// ==== verif/tb_board_support.sv ====
`timescale 1ns/1ps

module tb_board_support import board_pkg::*; ();

	localparam int MAX_CYCLES = 3000;

	logic clk_cpu;
	logic rst_n_i;
	logic pll_locked_i;
	logic btn_rst_i;
	logic wd_rst_i;
	switch_t switch_i;
	btn_t btn_i;
	logic irq_kbd_i;
	logic irq_spi_i;
	logic irq_uart_i;
	logic wb_cyc_i;
	logic wb_stb_i;
	bus_addr_t wb_addr_i;
	bsel_t wb_sel_i;
	logic wb_we_i;
	word_t wb_data_i;
	word_t wb_data_o;
	logic wb_ack_o;
	logic [DEV_SLOTS-1:0] dev_cs_o;
	dev_addr_t dev_addr_o;
	bsel_t dev_sel_o;
	logic dev_we_o;
	word_t dev_wdata_o;
	logic [DEV_SLOTS*WORD_W-1:0] dev_rdata_i;
	logic [DEV_SLOTS-1:0] dev_ack_i;
	irq_vec_t irq_o;
	switch_t led_o;
	logic sys_rst_o;
	logic bus_rst_o;

	int errors = 0;
	int cycle_cnt = 0;
	logic [31:0] rng = 32'd37633;
	logic [DEV_SLOTS-1:0] cs_seen;
	dev_addr_t addr_seen;

	board_support dut (.*);

	initial clk_cpu = 1'b0;
	always #50 clk_cpu = ~clk_cpu;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// what an external device returns for a given slot and offset
	function automatic word_t model_data(input int slot, input dev_addr_t off);
		return 32'h5a00_0000 | (slot << 16) | (32'(off) << 8) | ((slot * 7 + off) & 8'hff);
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (exp == got) else begin
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	// external devices answer one cycle after their select
	always @(posedge clk_cpu) begin
		cs_seen = dev_cs_o;
		addr_seen = dev_addr_o;
		#5;
		for (int i = 0; i < DEV_SLOTS; i++) begin
			if (cs_seen[i] && !dev_ack_i[i]) begin
				dev_ack_i[i] = 1'b1;
				dev_rdata_i[i*WORD_W +: WORD_W] = model_data(i, addr_seen);
			end else begin
				dev_ack_i[i] = 1'b0;
			end
		end
	end

	task automatic bus_access(input logic [7:0] slot, input dev_addr_t off, input bsel_t sel,
		input logic we, input word_t wdata, output word_t rdata, output int cycles,
		output logic instant);
		int n;
		logic [DEV_SLOTS-1:0] cs_exp;
		@(posedge clk_cpu);
		#5;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_addr_i = {slot, off};
		wb_sel_i = sel;
		wb_we_i = we;
		wb_data_i = wdata;
		#1;
		instant = wb_ack_o;
		cs_exp = '0;
		if (slot < DEV_SLOTS && slot != SLOT_BOARD) begin
			cs_exp[slot] = 1'b1;
			check_value("dev_addr_o", 32'(off), 32'(dev_addr_o));
			check_value("dev_sel_o", 32'(sel), 32'(dev_sel_o));
			check_value("dev_we_o", 32'(we), 32'(dev_we_o));
			check_value("dev_wdata_o", wdata, dev_wdata_o);
		end
		check_value("dev_cs_o", 32'(cs_exp), 32'(dev_cs_o));
		n = 0;
		do begin
			@(posedge clk_cpu);
			#1;
			n++;
		end while (!wb_ack_o && n < 20);
		if (!wb_ack_o) begin
			$display("no acknowledge from slot %0d at %0t", slot, $time);
			errors++;
		end
		rdata = wb_data_o;
		cycles = n;
		#4;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
	endtask

	task automatic board_read(input dev_addr_t off, input word_t exp, input string name);
		word_t rd;
		int cyc;
		logic inst;
		bus_access(8'(SLOT_BOARD), off, 4'hf, 1'b0, '0, rd, cyc, inst);
		check_value(name, exp, rd);
		check_value("board ack latency", 32'd1, 32'(cyc));
		check_value("board instant ack", 32'd0, 32'(inst));
	endtask

	task automatic board_write(input dev_addr_t off, input bsel_t sel, input word_t data);
		word_t rd;
		int cyc;
		logic inst;
		bus_access(8'(SLOT_BOARD), off, sel, 1'b1, data, rd, cyc, inst);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_cpu);
	endtask

	task automatic wait_release(input int limit);
		int n;
		n = 0;
		do begin
			@(posedge clk_cpu);
			#1;
			n++;
		end while (sys_rst_o && n < limit);
		if (sys_rst_o) begin
			$display("system reset never released at %0t", $time);
			errors++;
		end
	endtask

	assert property (@(posedge clk_cpu) disable iff (!rst_n_i)
		bus_rst_o == (sys_rst_o | wd_rst_i))
	else begin
		$display("[FAIL] %0t bus_rst_o expected %b got %b", $time, sys_rst_o | wd_rst_i, bus_rst_o);
		errors++;
	end

	// outputs quiet once reset has been seen for a full cycle
	assert property (@(posedge clk_cpu) disable iff (!rst_n_i)
		(sys_rst_o && $past(sys_rst_o)) |-> (irq_o == '0 && led_o == '0 && !wb_ack_o))
	else begin
		$display("[FAIL] %0t irq_o/led_o/wb_ack_o expected 0 got %h %h %b",
			$time, irq_o, led_o, wb_ack_o);
		errors++;
	end

	assert property (@(posedge clk_cpu) !dev_cs_o[SLOT_BOARD])
	else begin
		$display("[FAIL] %0t dev_cs_o[%0d] expected 0 got 1", $time, SLOT_BOARD);
		errors++;
	end

	assert property (@(posedge clk_cpu) disable iff (!rst_n_i) wb_ack_o |-> wb_stb_i)
	else begin
		$display("[FAIL] %0t wb_ack_o without wb_stb_i", $time);
		errors++;
	end

	always @(posedge clk_cpu) begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		int n;
		word_t rd;
		int cyc;
		logic inst;
		switch_t sw;
		switch_t led_m;
		bsel_t sel;
		word_t data;
		logic [7:0] slot;
		dev_addr_t off;
		logic we;
		irq_vec_t irq_exp;

		rst_n_i = 1'b0;
		pll_locked_i = 1'b0;
		btn_rst_i = 1'b0;
		wd_rst_i = 1'b0;
		switch_i = '0;
		btn_i = '0;
		irq_kbd_i = 1'b0;
		irq_spi_i = 1'b0;
		irq_uart_i = 1'b0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_addr_i = '0;
		wb_sel_i = '0;
		wb_we_i = 1'b0;
		wb_data_i = '0;
		dev_rdata_i = '0;
		dev_ack_i = '0;
		led_m = '0;

		wait_cycles(10);
		#5;
		rst_n_i = 1'b1;
		wait_cycles(15);

		// stretch after lock
		#5;
		pll_locked_i = 1'b1;
		@(posedge clk_cpu);
		#1;
		check_value("sys_rst_o", 32'd1, 32'(sys_rst_o));
		n = 0;
		do begin
			@(posedge clk_cpu);
			#1;
			n++;
		end while (sys_rst_o && n < 40);
		check_value("sys_rst_o release delay", 32'(RESET_HOLD + 1), 32'(n));

		// lock drop
		@(posedge clk_cpu);
		#5;
		pll_locked_i = 1'b0;
		@(posedge clk_cpu);
		#1;
		check_value("sys_rst_o", 32'd1, 32'(sys_rst_o));
		wait_cycles(3);
		#5;
		pll_locked_i = 1'b1;
		wait_release(40);

		// watchdog only touches the bus reset
		@(posedge clk_cpu);
		#5;
		wd_rst_i = 1'b1;
		#1;
		check_value("bus_rst_o", 32'd1, 32'(bus_rst_o));
		check_value("sys_rst_o", 32'd0, 32'(sys_rst_o));
		wait_cycles(2);
		#5;
		wd_rst_i = 1'b0;
		wait_cycles(2);

		// debounce
		for (int k = 0; k < 4; k++) begin
			rng = xorshift(rng);
			sw = rng[15:0];
			@(posedge clk_cpu);
			#5;
			switch_i = sw;
			wait_cycles(DEBOUNCE_CYCLES + 2);
			board_read(REG_SWITCH, 32'(sw), "REG_SWITCH");
			// glitch still present while the read is on the bus
			@(posedge clk_cpu);
			#5;
			switch_i = ~sw;
			wait_cycles(DEBOUNCE_CYCLES - 5);
			board_read(REG_SWITCH, 32'(sw), "REG_SWITCH during glitch");
			switch_i = sw;
		end

		// leds with byte enables
		for (int k = 0; k < 6; k++) begin
			rng = xorshift(rng);
			data = rng;
			rng = xorshift(rng);
			sel = rng[3:0];
			board_write(REG_LED, sel, data);
			if (sel[0]) led_m[7:0] = data[7:0];
			if (sel[1]) led_m[15:8] = data[15:8];
			check_value("led_o", 32'(led_m), 32'(led_o));
			board_read(REG_LED, 32'(led_m), "REG_LED");
		end

		// button event and board interrupt
		@(posedge clk_cpu);
		#5;
		btn_i = 4'b0010;
		wait_cycles(DEBOUNCE_CYCLES + 4);
		#1;
		check_value("irq_o[2]", 32'd1, 32'(irq_o[IRQ_POS_BOARD]));
		board_read(REG_BTN, 32'h2, "REG_BTN");
		btn_i = '0;
		wait_cycles(DEBOUNCE_CYCLES + 4);
		board_read(REG_EVENT, 32'h2, "REG_EVENT");
		board_write(REG_EVENT, 4'b0001, 32'h2);
		n = 0;
		while (irq_o[IRQ_POS_BOARD] && n < IRQ_HOLD + 2) begin
			@(posedge clk_cpu);
			#1;
			n++;
		end
		check_value("irq_o[2] after clear", 32'd0, 32'(irq_o[IRQ_POS_BOARD]));
		board_read(REG_EVENT, 32'h0, "REG_EVENT after clear");

		// one-cycle uart pulse
		@(posedge clk_cpu);
		#5;
		irq_uart_i = 1'b1;
		@(posedge clk_cpu);
		#5;
		irq_uart_i = 1'b0;
		n = 1;
		while (irq_o[IRQ_POS_UART] && n < 20) begin
			@(posedge clk_cpu);
			#1;
			if (irq_o[IRQ_POS_UART]) n++;
		end
		check_value("irq_o[6] high cycles", 32'(IRQ_HOLD + 1), 32'(n));

		// keyboard and spi line positions
		@(posedge clk_cpu);
		#5;
		irq_kbd_i = 1'b1;
		irq_spi_i = 1'b1;
		@(posedge clk_cpu);
		#1;
		irq_exp = '0;
		irq_exp[3] = 1'b1;
		irq_exp[5] = 1'b1;
		check_value("irq_o", 32'(irq_exp), 32'(irq_o));
		#4;
		irq_kbd_i = 1'b0;
		irq_spi_i = 1'b0;
		wait_cycles(IRQ_HOLD + 2);

		// external slots
		for (int k = 0; k < 12; k++) begin
			rng = xorshift(rng);
			case (rng % 3)
				0: slot = 8'd3;
				1: slot = 8'd5;
				default: slot = 8'd6;
			endcase
			off = rng[13:8];
			sel = rng[19:16];
			we = rng[24];
			rng = xorshift(rng);
			data = rng;
			bus_access(slot, off, sel, we, data, rd, cyc, inst);
			check_value("external ack latency", 32'd2, 32'(cyc));
			if (!we) check_value("wb_data_o", model_data(slot, off), rd);
		end

		// slots with no device
		for (int k = 0; k < 4; k++) begin
			rng = xorshift(rng);
			slot = 8'(DEV_SLOTS + rng % (256 - DEV_SLOTS));
			bus_access(slot, rng[13:8], 4'hf, 1'b0, '0, rd, cyc, inst);
			check_value("out of range instant ack", 32'd1, 32'(inst));
			check_value("out of range wb_data_o", 32'd0, rd);
		end

		// leds lit and a uart request while the system reset is held
		board_write(REG_LED, 4'b0011, 32'h0000_ffff);
		check_value("led_o", 32'h0000_ffff, 32'(led_o));
		@(posedge clk_cpu);
		#5;
		pll_locked_i = 1'b0;
		wait_cycles(2);
		#5;
		irq_uart_i = 1'b1;
		wait_cycles(3);
		#5;
		irq_uart_i = 1'b0;

		wait_cycles(5);
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
common/board_pkg.sv
design/debounce.sv
design/reset_seq.sv
design/irq_stretch.sv
devbus/dev_decoder.sv
devbus/board_regs.sv
design/board_support.sv
verif/tb_board_support.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the board support testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wall -Wno-fatal \
	-f verilog.f --top-module tb_board_support -o sim_board_support

./obj_dir/sim_board_support | tee sim.log

if grep -q "Simulation passed" sim.log; then
	exit 0
else
	exit 1
fi
